// ==== board_dip.sv ====
/* Settings word decoder */
`timescale 1ns/10ps

module board_dip (
    input  logic               clk_sys,
    input  logic               rst_n,
    input  board_pkg::status_t status,
    input  logic               game_pause,
    output board_pkg::dip_cfg_t dip
);
    import board_pkg::*;

    dip_cfg_t dip_dec;

    always_comb begin
        dip_dec.flip       = status[ST_FLIP];
        dip_dec.fxlevel    = status[ST_FX +: $bits(fxlevel_t)];
        // Sound chips are on unless the menu turns them off
        dip_dec.enable_fm  = ~status[ST_NOFM];
        dip_dec.enable_psg = ~status[ST_NOPSG];
        dip_dec.test       = status[ST_TEST];
        // Either the menu or the joystick can pause
        dip_dec.pause      = ~(status[ST_PAUSE] | game_pause);
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dip.test       <= 1'b0;
            dip.pause      <= 1'b1;
            dip.flip       <= 1'b0;
            dip.fxlevel    <= '0;
            dip.enable_fm  <= 1'b1;
            dip.enable_psg <= 1'b1;
        end else begin
            dip <= dip_dec;
        end
    end

endmodule

// ==== board_inputs.sv ====
/* Player input mapping */
`timescale 1ns/10ps

module board_inputs (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   game_rst_n,
    input  board_pkg::board_joys_t board_joys,
    output board_pkg::game_joys_t  game_joys,
    output board_pkg::game_ctrl_t  game_ctrl,
    output logic                   game_pause,
    output logic                   soft_rst
);
    import board_pkg::*;

    game_joys_t joys_map;
    game_ctrl_t ctrl_map;
    board_joy_t p1_joy;
    logic       p1_combo;
    logic       p1_combo_l;
    logic       p1_pause_l;

    // Directions plus the buttons the game uses
    // Unused upper bits read as released
    function automatic game_joy_t map_joy(board_joy_t bj);
        game_joy_t gj;
        gj = '0;
        gj[JOY_DIR_W-1:0]         = bj[JOY_DIR_W-1:0];
        gj[JOY_BTN_LSB +: BUTTONS] = bj[JOY_BTN_LSB +: BUTTONS];
        return ACTIVE_LOW ? ~gj : gj;
    endfunction

    always_comb begin
        ctrl_map = '0;
        for (int p = 0; p < NPLAYERS; p++) begin
            joys_map[p]       = map_joy(board_joys[p]);
            ctrl_map.coin[p]  = board_joys[p][JOY_COIN];
            ctrl_map.start[p] = board_joys[p][JOY_START];
            ctrl_map.service  = ctrl_map.service | board_joys[p][JOY_SERVICE];
        end
        if (ACTIVE_LOW) begin
            ctrl_map = ~ctrl_map;
        end
    end

    assign p1_joy   = board_joys[0];
    assign p1_combo = p1_joy[JOY_START] & p1_joy[JOY_COIN];

    // Game side outputs read released while the game is in reset
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_joys <= {$bits(game_joys_t){ACTIVE_LOW}};
            game_ctrl <= {$bits(game_ctrl_t){ACTIVE_LOW}};
        end else if (!game_rst_n) begin
            game_joys <= {$bits(game_joys_t){ACTIVE_LOW}};
            game_ctrl <= {$bits(game_ctrl_t){ACTIVE_LOW}};
        end else begin
            game_joys <= joys_map;
            game_ctrl <= ctrl_map;
        end
    end

    // Player 1 edge detectors
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            p1_combo_l <= 1'b0;
            p1_pause_l <= 1'b0;
            soft_rst   <= 1'b0;
            game_pause <= 1'b0;
        end else begin
            p1_combo_l <= p1_combo;
            p1_pause_l <= p1_joy[JOY_PAUSE];
            // Start and coin together ask for a game reset
            soft_rst   <= p1_combo & ~p1_combo_l;
            if (!game_rst_n) begin
                game_pause <= 1'b0;
            end else if (p1_joy[JOY_PAUSE] && !p1_pause_l) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

// ==== board_led.sv ====
/* Status LED driver */
`timescale 1ns/10ps

module board_led (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       downloading,
    input  logic       game_pause,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);
    import board_pkg::*;

    logic [LED_CNT_W-1:0] blink_cnt;
    logic                 led_src;

    // Fast blink for ROM loading, slow blink for pause
    always_comb begin
        if (downloading) begin
            led_src = blink_cnt[LED_FAST_BITS];
        end else if (game_pause) begin
            led_src = blink_cnt[LED_SLOW_BITS];
        end else if (osd_shown) begin
            led_src = 1'b1;
        end else begin
            led_src = game_led[0];
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            blink_cnt <= '0;
            led       <= 1'b0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
            led       <= led_src;
        end
    end

endmodule

// ==== board_pkg.sv ====
/* Board glue shared definitions */
package board_pkg;

    // Game build options
    localparam int BUTTONS    = 4;
    localparam bit ACTIVE_LOW = 1'b1;
    localparam int NPLAYERS   = 4;

    // Reset and LED timing
    localparam int RST_HOLD      = 16;
    localparam int RST_CNT_W     = $clog2(RST_HOLD + 1);
    localparam int LED_FAST_BITS = 3;
    localparam int LED_SLOW_BITS = 5;
    localparam int LED_CNT_W     = LED_SLOW_BITS + 1;

    // Word widths
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;
    localparam int STATUS_W    = 32;

    // Board joystick layout with buttons 1 to 6 above the directions
    localparam int JOY_DIR_W   = 4;
    localparam int JOY_BTN_LSB = 4;
    localparam int JOY_START   = 10;
    localparam int JOY_COIN    = 11;
    localparam int JOY_PAUSE   = 12;
    localparam int JOY_SERVICE = 13;

    // Status word layout
    localparam int ST_FLIP  = 1;
    localparam int ST_FX    = 2;  // LSB of the 2-bit field
    localparam int ST_NOFM  = 4;
    localparam int ST_NOPSG = 5;
    localparam int ST_TEST  = 6;
    localparam int ST_PAUSE = 7;

    typedef logic [BOARD_JOY_W-1:0] board_joy_t;
    typedef logic [GAME_JOY_W-1:0]  game_joy_t;
    typedef logic [STATUS_W-1:0]    status_t;
    typedef logic [1:0]             fxlevel_t;
    typedef logic [NPLAYERS-1:0]    player_t;

    // Player 1 in slot 0
    typedef logic [NPLAYERS-1:0][BOARD_JOY_W-1:0] board_joys_t;
    typedef logic [NPLAYERS-1:0][GAME_JOY_W-1:0]  game_joys_t;

    typedef struct packed {
        player_t coin;
        player_t start;
        logic    service;
    } game_ctrl_t;

    typedef struct packed {
        logic     test;
        logic     pause;      // active low
        logic     flip;
        fxlevel_t fxlevel;
        logic     enable_fm;
        logic     enable_psg;
    } dip_cfg_t;

endpackage

// ==== board_reset.sv ====
/* Game reset sequencer */
`timescale 1ns/10ps

module board_reset (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic downloading,
    input  logic soft_rst,
    output logic game_rst_n
);
    import board_pkg::*;

    logic                 rst_cause;
    logic [RST_CNT_W-1:0] hold_cnt;
    logic [RST_CNT_W-1:0] hold_nxt;

    // Any of these keeps the game in reset
    assign rst_cause = ~pll_locked | downloading | soft_rst;

    // Reload while a cause is present, then count down to zero
    always_comb begin
        if (rst_cause) begin
            hold_nxt = RST_CNT_W'(RST_HOLD);
        end else if (hold_cnt != '0) begin
            hold_nxt = hold_cnt - 1'b1;
        end else begin
            hold_nxt = '0;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt   <= RST_CNT_W'(RST_HOLD);
            game_rst_n <= 1'b0;
        end else begin
            hold_cnt   <= hold_nxt;
            // Release only once the hold period has fully elapsed
            game_rst_n <= (hold_nxt == '0);
        end
    end

endmodule

// ==== board_top.sv ====
/* Arcade board glue top level */
`timescale 1ns/10ps

module board_top (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   pll_locked,
    input  logic                   downloading,
    input  logic                   osd_shown,
    input  logic [1:0]             game_led,
    input  board_pkg::status_t     status,
    input  board_pkg::board_joys_t board_joys,
    output logic                   game_rst_n,
    output board_pkg::game_joys_t  game_joys,
    output board_pkg::game_ctrl_t  game_ctrl,
    output board_pkg::dip_cfg_t    dip,
    output logic                   led
);

    logic soft_rst;
    logic game_pause;

    board_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .game_rst_n  ( game_rst_n  )
    );

    board_inputs u_inputs (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .game_rst_n  ( game_rst_n  ),
        .board_joys  ( board_joys  ),
        .game_joys   ( game_joys   ),
        .game_ctrl   ( game_ctrl   ),
        .game_pause  ( game_pause  ),
        .soft_rst    ( soft_rst    )
    );

    board_dip u_dip (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .status      ( status      ),
        .game_pause  ( game_pause  ),
        .dip         ( dip         )
    );

    // LED shares the pause level with the DIP decoder
    board_led u_led (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .game_pause  ( game_pause  ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

endmodule

// ==== project.f ====
board_pkg.sv
board_reset.sv
board_inputs.sv
board_dip.sv
board_led.sv
board_top.sv
tb_clkgen.sv
tb_board.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the board glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/tb_board_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board -f project.f -o tb_board_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

// ==== tb_board.sv ====
/* Board glue testbench */
`timescale 1ns/10ps

module tb_board;
    import board_pkg::*;

    logic        clk_sys;
    logic        rst_n;
    logic        pll_locked;
    logic        downloading;
    logic        osd_shown;
    logic [1:0]  game_led;
    status_t     status;
    board_joys_t board_joys;
    logic        game_rst_n;
    game_joys_t  game_joys;
    game_ctrl_t  game_ctrl;
    dip_cfg_t    dip;
    logic        led;

    integer      seed;
    logic        map_chk;
    logic        dip_chk;
    logic        prev_map_ok;
    logic        prev_dip_ok;
    board_joys_t prev_joys;
    status_t     prev_status;
    board_joys_t rnd_joys;

    tb_clkgen u_clkgen (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   )
    );

    board_top DUT (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .status      ( status      ),
        .board_joys  ( board_joys  ),
        .game_rst_n  ( game_rst_n  ),
        .game_joys   ( game_joys   ),
        .game_ctrl   ( game_ctrl   ),
        .dip         ( dip         ),
        .led         ( led         )
    );

    // Directions and used buttons pass through
    // Upper bits read as released
    function automatic game_joys_t expect_joys(board_joys_t bj);
        game_joys_t gj;
        logic       pressed;
        for (int p = 0; p < NPLAYERS; p++) begin
            for (int b = 0; b < GAME_JOY_W; b++) begin
                pressed  = (b < JOY_BTN_LSB + BUTTONS) ? bj[p][b] : 1'b0;
                gj[p][b] = pressed ^ ACTIVE_LOW;
            end
        end
        return gj;
    endfunction

    function automatic game_ctrl_t expect_ctrl(board_joys_t bj);
        game_ctrl_t gc;
        logic       any_service;
        any_service = 1'b0;
        for (int p = 0; p < NPLAYERS; p++) begin
            gc.coin[p]  = bj[p][JOY_COIN] ^ ACTIVE_LOW;
            gc.start[p] = bj[p][JOY_START] ^ ACTIVE_LOW;
            any_service = any_service || bj[p][JOY_SERVICE];
        end
        gc.service = any_service ^ ACTIVE_LOW;
        return gc;
    endfunction

    function automatic dip_cfg_t expect_dip(status_t st, logic paused);
        dip_cfg_t d;
        d.test       = st[ST_TEST];
        d.pause      = !(st[ST_PAUSE] || paused);
        d.flip       = st[ST_FLIP];
        d.fxlevel    = st[ST_FX +: 2];
        d.enable_fm  = !st[ST_NOFM];
        d.enable_psg = !st[ST_NOPSG];
        return d;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(string test, string what, logic [63:0] exp, logic [63:0] act);
        assert (act === exp) else begin
            report_failure($sformatf("FAIL %s: %s expected %h actual %h",
                                     test, what, exp, act));
        end
    endtask

    task automatic tick();
        @(posedge clk_sys);
        #2;
    endtask

    task automatic wait_dip_pause(logic val, int limit, string test);
        int n;
        n = 0;
        while (dip.pause !== val && n < limit) begin
            tick();
            n++;
        end
        assert (dip.pause === val) else begin
            report_failure($sformatf("%s: dip.pause did not reach %0b within %0d cycles",
                                     test, val, limit));
        end
    endtask

    task automatic wait_game_rst(logic val, int limit, string test);
        int n;
        n = 0;
        while (game_rst_n !== val && n < limit) begin
            tick();
            n++;
        end
        assert (game_rst_n === val) else begin
            report_failure($sformatf("%s: game_rst_n did not reach %0b within %0d cycles",
                                     test, val, limit));
        end
    endtask

    task automatic wait_led_toggle(int limit, string test);
        logic start;
        int   n;
        start = led;
        n     = 0;
        while (led === start && n < limit) begin
            tick();
            n++;
        end
        assert (led !== start) else begin
            report_failure($sformatf("%s: led did not toggle within %0d cycles", test, limit));
        end
    endtask

    // Pause the game from player 1 before a reset case
    task automatic set_pause(string test);
        board_joys[0][JOY_PAUSE] = 1'b1;
        wait_dip_pause(1'b0, 4, test);
        board_joys[0][JOY_PAUSE] = 1'b0;
        tick();
    endtask

    // Count low cycles and check released outputs while in reset
    task automatic measure_reset(string test);
        int low_cnt;
        low_cnt = 0;
        while (game_rst_n === 1'b0 && low_cnt < RST_HOLD + 40) begin
            low_cnt++;
            if (low_cnt >= 3) begin
                check_eq(test, "game_joys in reset",
                         64'(expect_joys('0)), 64'(game_joys));
                check_eq(test, "game_ctrl in reset",
                         64'(expect_ctrl('0)), 64'(game_ctrl));
                check_eq(test, "dip.pause in reset", 64'(1), 64'(dip.pause));
            end
            tick();
        end
        assert (game_rst_n === 1'b1) else begin
            report_failure($sformatf("%s: game_rst_n stayed low for over %0d cycles",
                                     test, low_cnt));
        end
        assert (low_cnt >= RST_HOLD) else begin
            report_failure($sformatf("FAIL %s: reset low cycles expected at least %0d actual %0d",
                                     test, RST_HOLD, low_cnt));
        end
    endtask

    // Outputs at a falling edge reflect the inputs seen one edge earlier
    always @(negedge clk_sys) begin
        if (map_chk && prev_map_ok) begin
            check_eq("input_mapping", "game_joys", 64'(expect_joys(prev_joys)), 64'(game_joys));
            check_eq("input_mapping", "game_ctrl", 64'(expect_ctrl(prev_joys)), 64'(game_ctrl));
        end
        if (dip_chk && prev_dip_ok) begin
            check_eq("dip_decoding", "dip", 64'(expect_dip(prev_status, 1'b0)), 64'(dip));
        end
        prev_joys   = board_joys;
        prev_status = status;
        prev_map_ok = map_chk && game_rst_n;
        prev_dip_ok = dip_chk;
    end

    initial begin
        seed        = 32'hcf9;
        pll_locked  = 1'b1;
        downloading = 1'b0;
        osd_shown   = 1'b0;
        game_led    = 2'b00;
        status      = '0;
        board_joys  = '0;
        map_chk     = 1'b0;
        dip_chk     = 1'b0;
        prev_map_ok = 1'b0;
        prev_dip_ok = 1'b0;

        wait_game_rst(1'b1, 10 + RST_HOLD + 20, "startup");
        tick();

        // Random joysticks without the start and coin combo or a pause press
        map_chk = 1'b1;
        for (int i = 0; i < 200; i++) begin
            rnd_joys = {$random(seed), $random(seed)};
            rnd_joys[0][JOY_PAUSE] = 1'b0;
            if (rnd_joys[0][JOY_START] && rnd_joys[0][JOY_COIN]) begin
                rnd_joys[0][JOY_COIN] = 1'b0;
            end
            board_joys = rnd_joys;
            tick();
        end

        // Random settings words
        dip_chk = 1'b1;
        for (int i = 0; i < 200; i++) begin
            status = $random(seed);
            tick();
        end
        status = '0;
        status[ST_PAUSE] = 1'b1;
        tick();
        tick();
        check_eq("dip_decoding", "dip.pause with menu pause", 64'(0), 64'(dip.pause));
        map_chk    = 1'b0;
        dip_chk    = 1'b0;
        status     = '0;
        board_joys = '0;
        tick();
        tick();

        // Pause toggles on player 1 and blinks the LED slowly
        set_pause("pause_toggle");
        wait_led_toggle(2 * 32, "pause_toggle");
        wait_led_toggle(2 * 32, "pause_toggle");
        board_joys[0][JOY_PAUSE] = 1'b1;
        wait_dip_pause(1'b1, 4, "pause_toggle");
        board_joys[0][JOY_PAUSE] = 1'b0;
        tick();
        tick();
        check_eq("pause_toggle", "led after release", 64'(game_led[0]), 64'(led));

        // Reset from a ROM download
        set_pause("reset_download");
        board_joys[1] = 16'h3fff;
        downloading   = 1'b1;
        wait_game_rst(1'b0, 4, "reset_download");
        repeat (3) tick();
        downloading = 1'b0;
        measure_reset("reset_download");

        // Reset from player 1 start and coin
        board_joys = '0;
        tick();
        set_pause("reset_soft");
        board_joys[1] = 16'h3fff;
        board_joys[0][JOY_START] = 1'b1;
        board_joys[0][JOY_COIN]  = 1'b1;
        wait_game_rst(1'b0, 5, "reset_soft");
        measure_reset("reset_soft");
        board_joys = '0;
        tick();
        check_eq("reset_soft", "dip.pause after reset", 64'(1), 64'(dip.pause));

        // LED priorities
        downloading = 1'b1;
        wait_led_toggle(2 * 8, "led_priority");
        wait_led_toggle(2 * 8, "led_priority");
        downloading = 1'b0;
        wait_game_rst(1'b1, RST_HOLD + 10, "led_priority");
        osd_shown = 1'b1;
        game_led  = 2'b10;
        tick();
        check_eq("led_priority", "led with osd", 64'(1), 64'(led));
        osd_shown = 1'b0;
        for (int i = 0; i < 16; i++) begin
            game_led = 2'($random(seed));
            tick();
            check_eq("led_priority", "led from game", 64'(game_led[0]), 64'(led));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tb_clkgen.sv ====
/* Testbench clock and reset */
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk_sys,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // Reset held for 10 cycles and released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk_sys);
        #2 rst_n = 1'b1;
    end

endmodule
